// ==== include/crc_ahb_settings.svh ====
// bus widths, register offsets, crc seed and polynomial defines
`ifndef CRC_AHB_SETTINGS_SVH
`define CRC_AHB_SETTINGS_SVH

// bus widths
`define AHB_DATA_W      64          // ahb data bus, two 32b lanes
`define AHB_ADDR_W      32
`define CLIENT_DATA_W   32          // register side is word wide
`define CLIENT_ADDR_W   12          // 4k register window

// register map, byte offsets on the client bus
`define REG_CTRL        12'h000     // bit 0 init pulse, reads 0
`define REG_SEED        12'h004     // rw
`define REG_DATA        12'h008     // wo, one word per write
`define REG_RESULT      12'h00C     // ro, inverted crc
`define REG_STATUS      12'h010     // ro, busy and byte count

// status field positions
`define STATUS_BUSY_BIT 0
`define STATUS_CNT_LSB  16

// crc-32, reflected form of 0x04c11db7
`define SEED_RESET      32'hFFFF_FFFF
`define CRC_POLY        32'hEDB8_8320

`endif

// ==== hdl/crc_ahb_pkg.sv ====
// crc_ahb_pkg with bus vector typedefs, ahb enums, register select and engine state
`include "crc_ahb_settings.svh"

package crc_ahb_pkg;

    // ahb side vectors
    typedef logic [`AHB_ADDR_W-1:0]    ahb_addr_t;
    typedef logic [`AHB_DATA_W-1:0]    ahb_data_t;

    // client side vectors
    typedef logic [`CLIENT_ADDR_W-1:0] client_addr_t;
    typedef logic [`CLIENT_DATA_W-1:0] client_data_t;

    typedef logic [31:0] crc_t;        // running crc value
    typedef logic [15:0] byte_cnt_t;   // bytes since init, wraps

    // hresp, ahb-lite only uses okay and error
    typedef enum logic {
        H_OKAY  = 1'b0,
        H_ERROR = 1'b1
    } hresp_e;

    // htrans encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // decoded register
    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_SEED,
        SEL_DATA,
        SEL_RESULT,
        SEL_STATUS,
        REG_NONE                       // unmapped offset
    } reg_sel_e;

    typedef enum logic {
        ENG_IDLE,
        ENG_RUN                        // one byte per clock
    } eng_state_e;

endpackage

// ==== hdl/client_bus_if.sv ====
// client_bus_if, word bus between the ahb front end and the register block
`timescale 1ns/10ps

interface client_bus_if;

    logic                      dv;     // transfer in data phase
    logic                      write;
    crc_ahb_pkg::client_addr_t addr;
    crc_ahb_pkg::client_data_t wdata;  // lane selected, zero extended
    logic                      hld;    // stall, combinational
    logic                      err;    // illegal access, combinational
    crc_ahb_pkg::client_data_t rdata;

    // ahb front end side
    modport slv (
        output dv, write, addr, wdata,
        input  hld, err, rdata
    );

    // register block side
    modport regs (
        input  dv, write, addr, wdata,
        output hld, err, rdata
    );

endinterface

// ==== hdl/ahb_slv_sif.sv ====
// ahb_slv_sif, ahb-lite slave front end onto the client bus
`timescale 1ns/10ps
`include "crc_ahb_settings.svh"

module ahb_slv_sif (
    input  logic                   hclk,
    input  logic                   hreset_n,

    // ahb-lite slave
    input  crc_ahb_pkg::ahb_addr_t haddr_i,
    input  crc_ahb_pkg::ahb_data_t hwdata_i,
    input  logic                   hsel_i,
    input  logic                   hwrite_i,
    input  logic                   hready_i,
    input  crc_ahb_pkg::htrans_e   htrans_i,
    input  logic [2:0]             hsize_i,
    output crc_ahb_pkg::hresp_e    hresp_o,
    output logic                   hreadyout_o,
    output crc_ahb_pkg::ahb_data_t hrdata_o,

    // register side
    client_bus_if.slv              cb
);

    logic                      addr_phase;  // accepted address phase this cycle
    logic                      err_f;       // second error cycle
    logic [2:0]                size;        // captured hsize
    crc_ahb_pkg::client_data_t lane;        // 32b half of hwdata

    // only nonseq and seq carry a transfer
    assign addr_phase = hsel_i & hready_i &
                        ((htrans_i == crc_ahb_pkg::NONSEQ) |
                         (htrans_i == crc_ahb_pkg::SEQ));

    // address phase capture
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            cb.dv    <= 1'b0;
            cb.write <= 1'b0;
            cb.addr  <= '0;
        end else begin
            if (hready_i) begin
                cb.dv <= addr_phase;  // dv holds while data phase stalls
            end
            if (addr_phase) begin
                cb.addr  <= haddr_i[`CLIENT_ADDR_W-1:0];
                cb.write <= hwrite_i;
            end
        end
    end

    // transfer size for the data phase
    always_ff @(posedge hclk) begin
        if (addr_phase) begin
            size <= hsize_i;
        end
    end

    // write data lane, addr bit 2 picks the upper word
    assign lane = cb.addr[2] ? hwdata_i[`AHB_DATA_W-1:`CLIENT_DATA_W]
                             : hwdata_i[`CLIENT_DATA_W-1:0];

    always_comb begin
        unique case (size) inside
            3'b000:  cb.wdata = {{(`CLIENT_DATA_W-8){1'b0}}, lane[7:0]};    // byte
            3'b001:  cb.wdata = {{(`CLIENT_DATA_W-16){1'b0}}, lane[15:0]};  // halfword
            default: cb.wdata = lane;                                      // word
        endcase
    end

    // read data back on the same lane
    assign hrdata_o = cb.addr[2] ? {cb.rdata, {`CLIENT_DATA_W{1'b0}}}
                                 : {{`CLIENT_DATA_W{1'b0}}, cb.rdata};

    // two cycle error tracking
    // set after the first error cycle, cleared after the second
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            err_f <= 1'b0;
        end else begin
            err_f <= cb.err & ~err_f;
        end
    end

    always_comb begin : response_block
        hreadyout_o = 1'b1;
        hresp_o     = crc_ahb_pkg::H_OKAY;
        if (err_f) begin
            // second error cycle, complete with error
            hreadyout_o = 1'b1;
            hresp_o     = crc_ahb_pkg::H_ERROR;
        end else if (cb.err) begin
            // first error cycle, stall and flag
            hreadyout_o = 1'b0;
            hresp_o     = crc_ahb_pkg::H_ERROR;
        end else if (cb.dv & cb.hld) begin
            hreadyout_o = 1'b0;  // register side wait state
        end
    end

    // error response is the full two cycle sequence on a still live transfer
    err_two_cycle_a: assert property (@(posedge hclk) disable iff (!hreset_n)
        (hresp_o == crc_ahb_pkg::H_ERROR && !hreadyout_o)
        |=> (hresp_o == crc_ahb_pkg::H_ERROR && hreadyout_o && cb.dv));

endmodule

// ==== hdl/crc_regs.sv ====
// crc_regs, register decode, seed register, hold and error, engine strobes
`timescale 1ns/10ps
`include "crc_ahb_settings.svh"

module crc_regs (
    input  logic                      hclk,
    input  logic                      hreset_n,

    client_bus_if.regs                cb,

    // engine side
    input  logic                      busy_i,
    input  crc_ahb_pkg::crc_t         crc_i,
    input  crc_ahb_pkg::byte_cnt_t    byte_cnt_i,
    output logic                      start_o,
    output crc_ahb_pkg::client_data_t data_o,
    output logic                      init_o,
    output crc_ahb_pkg::crc_t         seed_o
);

    crc_ahb_pkg::reg_sel_e sel;
    crc_ahb_pkg::crc_t     seed_q;
    logic                  wr_done;     // write completes on this edge
    logic                  ro_write;    // write to a read-only register

    // address decode
    always_comb begin
        unique case (cb.addr)
            `REG_CTRL:   sel = crc_ahb_pkg::SEL_CTRL;
            `REG_SEED:   sel = crc_ahb_pkg::SEL_SEED;
            `REG_DATA:   sel = crc_ahb_pkg::SEL_DATA;
            `REG_RESULT: sel = crc_ahb_pkg::SEL_RESULT;
            `REG_STATUS: sel = crc_ahb_pkg::SEL_STATUS;
            default:     sel = crc_ahb_pkg::REG_NONE;
        endcase
    end

    assign ro_write = cb.write & ((sel == crc_ahb_pkg::SEL_RESULT) |
                                  (sel == crc_ahb_pkg::SEL_STATUS));

    // stall data writes and result reads until the engine drains
    assign cb.hld = cb.dv & busy_i &
                    (( cb.write & (sel == crc_ahb_pkg::SEL_DATA)) |
                     (~cb.write & (sel == crc_ahb_pkg::SEL_RESULT)));

    assign cb.err = cb.dv & ((sel == crc_ahb_pkg::REG_NONE) | ro_write);

    assign wr_done = cb.dv & cb.write & ~cb.hld & ~cb.err;

    // seed register
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            seed_q <= `SEED_RESET;
        end else if (wr_done && sel == crc_ahb_pkg::SEL_SEED) begin
            seed_q <= cb.wdata;  // sub-word writes arrive zero extended
        end
    end

    // engine strobes, single cycle, same cycle as completion
    assign start_o = wr_done & (sel == crc_ahb_pkg::SEL_DATA);
    assign data_o  = cb.wdata;
    assign init_o  = wr_done & (sel == crc_ahb_pkg::SEL_CTRL) & cb.wdata[0];
    assign seed_o  = seed_q;

    // read mux
    always_comb begin
        cb.rdata = '0;  // ctrl, data and unmapped read 0
        unique case (sel)
            crc_ahb_pkg::SEL_SEED:   cb.rdata = seed_q;
            crc_ahb_pkg::SEL_RESULT: cb.rdata = ~crc_i;  // final xor
            crc_ahb_pkg::SEL_STATUS: begin
                cb.rdata[`STATUS_BUSY_BIT]                   = busy_i;
                cb.rdata[`STATUS_CNT_LSB +: 16]              = byte_cnt_i;
            end
            default: ;
        endcase
    end

    // a stalled transfer is never an error and stays live through the stall
    hld_err_excl_a: assert property (@(posedge hclk) disable iff (!hreset_n)
        cb.hld |-> !cb.err ##1 (cb.dv && !cb.err));

    // data words only reach an idle engine, which then goes busy
    start_idle_a: assert property (@(posedge hclk) disable iff (!hreset_n)
        start_o |-> !busy_i ##1 busy_i);

endmodule

// ==== hdl/crc_engine.sv ====
// crc_engine, byte serial crc-32 with busy and byte count
`timescale 1ns/10ps
`include "crc_ahb_settings.svh"

module crc_engine (
    input  logic                      hclk,
    input  logic                      hreset_n,
    input  logic                      start_i,
    input  logic                      init_i,
    input  crc_ahb_pkg::client_data_t data_i,
    input  crc_ahb_pkg::crc_t         seed_i,
    output logic                      busy_o,
    output crc_ahb_pkg::crc_t         crc_o,
    output crc_ahb_pkg::byte_cnt_t    byte_cnt_o
);

    crc_ahb_pkg::eng_state_e   state;
    crc_ahb_pkg::crc_t         crc_q;
    crc_ahb_pkg::byte_cnt_t    byte_cnt_q;
    crc_ahb_pkg::client_data_t shift_q;   // word being consumed, lsb first
    logic [1:0]                step_q;    // byte index within the word

    // one byte through eight reflected polynomial steps
    function automatic crc_ahb_pkg::crc_t crc_byte(input crc_ahb_pkg::crc_t c,
                                                   input logic [7:0] b);
        crc_ahb_pkg::crc_t r;
        r = c ^ {24'b0, b};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ `CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            state      <= crc_ahb_pkg::ENG_IDLE;
            crc_q      <= `SEED_RESET;
            byte_cnt_q <= '0;
            step_q     <= '0;
        end else if (init_i) begin
            state      <= crc_ahb_pkg::ENG_IDLE;  // init also aborts a word
            crc_q      <= seed_i;
            byte_cnt_q <= '0;
            step_q     <= '0;
        end else begin
            unique case (state)
                crc_ahb_pkg::ENG_IDLE: begin
                    if (start_i) begin
                        state  <= crc_ahb_pkg::ENG_RUN;
                        step_q <= '0;
                    end
                end
                crc_ahb_pkg::ENG_RUN: begin
                    crc_q      <= crc_byte(crc_q, shift_q[7:0]);
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    step_q     <= step_q + 1'b1;
                    if (step_q == 2'd3) begin
                        state <= crc_ahb_pkg::ENG_IDLE;  // four bytes done
                    end
                end
                default: state <= crc_ahb_pkg::ENG_IDLE;
            endcase
        end
    end

    // word shifter, low byte leaves first
    always_ff @(posedge hclk) begin
        if (start_i && state == crc_ahb_pkg::ENG_IDLE) begin
            shift_q <= data_i;
        end else if (state == crc_ahb_pkg::ENG_RUN) begin
            shift_q <= shift_q >> 8;
        end
    end

    assign busy_o     = (state == crc_ahb_pkg::ENG_RUN);
    assign crc_o      = crc_q;
    assign byte_cnt_o = byte_cnt_q;

    // ctrl and data are separate registers, never written together
    init_start_excl_a: assert property (@(posedge hclk) disable iff (!hreset_n)
        !(init_i && start_i));

endmodule

// ==== hdl/crc_ahb_top.sv ====
// crc_ahb_top, ahb-lite crc-32 accelerator top level
`timescale 1ns/10ps

module crc_ahb_top (
    input  logic                   hclk,
    input  logic                   hreset_n,

    // ahb-lite slave port
    input  crc_ahb_pkg::ahb_addr_t haddr_i,
    input  crc_ahb_pkg::ahb_data_t hwdata_i,
    input  logic                   hsel_i,
    input  logic                   hwrite_i,
    input  logic                   hready_i,
    input  crc_ahb_pkg::htrans_e   htrans_i,
    input  logic [2:0]             hsize_i,
    output crc_ahb_pkg::hresp_e    hresp_o,
    output logic                   hreadyout_o,
    output crc_ahb_pkg::ahb_data_t hrdata_o
);

    // regs to engine
    logic                      start;
    logic                      init;
    crc_ahb_pkg::client_data_t data;
    crc_ahb_pkg::crc_t         seed;
    logic                      busy;
    crc_ahb_pkg::crc_t         crc;
    crc_ahb_pkg::byte_cnt_t    byte_cnt;

    client_bus_if cb_if ();

    ahb_slv_sif ahb_slv_sif_i (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .htrans_i    (htrans_i),
        .hsize_i     (hsize_i),
        .hresp_o     (hresp_o),
        .hreadyout_o (hreadyout_o),
        .hrdata_o    (hrdata_o),
        .cb          (cb_if.slv)
    );

    crc_regs crc_regs_i (
        .hclk       (hclk),
        .hreset_n   (hreset_n),
        .cb         (cb_if.regs),
        .busy_i     (busy),
        .crc_i      (crc),
        .byte_cnt_i (byte_cnt),
        .start_o    (start),
        .data_o     (data),
        .init_o     (init),
        .seed_o     (seed)
    );

    crc_engine crc_engine_i (
        .hclk       (hclk),
        .hreset_n   (hreset_n),
        .start_i    (start),
        .init_i     (init),
        .data_i     (data),
        .seed_i     (seed),
        .busy_o     (busy),
        .crc_o      (crc),
        .byte_cnt_o (byte_cnt)
    );

endmodule

// ==== sim/tb_crc_ahb.sv ====
// tb_crc_ahb, directed testbench with ahb master tasks, crc-32 model, tests and watchdog
`timescale 1ns/10ps
`include "crc_ahb_settings.svh"

module tb_crc_ahb;

    localparam int          CLK_HALF    = 2;                          // 4 ns period
    localparam int          NUM_XFERS   = 52;                         // 3+4+5+26+6+8
    localparam int          WATCHDOG_NS = (NUM_XFERS * 20 + 1000) * 4;
    localparam logic [31:0] BASE        = 32'h4000_0000;              // upper bits unused

    logic                   hclk;
    logic                   hreset_n;
    crc_ahb_pkg::ahb_addr_t haddr;
    crc_ahb_pkg::ahb_data_t hwdata;
    logic                   hsel;
    logic                   hwrite;
    crc_ahb_pkg::htrans_e   htrans;
    logic [2:0]             hsize;
    crc_ahb_pkg::hresp_e    hresp;
    logic                   hreadyout;
    crc_ahb_pkg::ahb_data_t hrdata;

    int                     seed;            // $random state
    int                     test_errs;       // errors in the running test
    int                     tests_passed;
    int                     tests_failed;
    int                     xfer_cycles;     // data phase length of the last transfer
    logic                   xfer_err_stall;  // saw ERROR with hreadyout low
    crc_ahb_pkg::ahb_data_t last_hrdata;     // raw 64b read data

    crc_ahb_top crc_ahb_top_i (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hwrite_i    (hwrite),
        .hready_i    (hreadyout),   // single slave, hready loops back
        .htrans_i    (htrans),
        .hsize_i     (hsize),
        .hresp_o     (hresp),
        .hreadyout_o (hreadyout),
        .hrdata_o    (hrdata)
    );

    initial begin
        hclk = 1'b0;
        forever #CLK_HALF hclk = ~hclk;
    end

    // reflected crc-32, bit at a time, bytes lsb first
    function automatic logic [31:0] crc_model(input logic [31:0] crc, input logic [31:0] word);
        logic [31:0] c;
        logic [7:0]  b;
        c = crc;
        for (int k = 0; k < 4; k++) begin
            b = word[8*k +: 8];
            for (int i = 0; i < 8; i++) begin
                if (c[0] ^ b[i])
                    c = (c >> 1) ^ `CRC_POLY;
                else
                    c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAIL t=%0t %s: got %08h, expected %08h", $time, what, got, exp);
        test_errs++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // one nonseq beat, no pipelining with the previous data phase
    task automatic address_phase(input logic [11:0] off, input logic wr, input logic [2:0] size);
        @(posedge hclk);
        haddr  <= BASE | off;
        hwrite <= wr;
        hsize  <= size;
        hsel   <= 1'b1;
        htrans <= crc_ahb_pkg::NONSEQ;
        @(posedge hclk);               // slave takes the address here
        hsel   <= 1'b0;
        htrans <= crc_ahb_pkg::IDLE;
    endtask

    // sample at negedge until hreadyout is high
    task automatic data_phase(output crc_ahb_pkg::hresp_e resp);
        xfer_cycles    = 0;
        xfer_err_stall = 1'b0;
        do begin
            @(negedge hclk);
            xfer_cycles++;
            if (!hreadyout && hresp == crc_ahb_pkg::H_ERROR)
                xfer_err_stall = 1'b1;
        end while (!hreadyout);
        resp        = hresp;
        last_hrdata = hrdata;
    endtask

    task automatic ahb_write(input logic [11:0] off, input logic [2:0] size,
                             input logic [31:0] data, output crc_ahb_pkg::hresp_e resp);
        address_phase(off, 1'b1, size);
        hwdata <= off[2] ? {data, ~data} : {~data, data};  // junk on the unused lane
        data_phase(resp);
    endtask

    task automatic ahb_read(input logic [11:0] off, output logic [31:0] data,
                            output crc_ahb_pkg::hresp_e resp);
        address_phase(off, 1'b0, 3'b010);
        data_phase(resp);
        data = off[2] ? last_hrdata[63:32] : last_hrdata[31:0];
    endtask

    task automatic test_reset_values();
        logic [31:0]         d;
        crc_ahb_pkg::hresp_e r;
        ahb_read(`REG_SEED, d, r);
        if (d !== `SEED_RESET)
            report_mismatch("seed after reset", d, `SEED_RESET);
        if (r !== crc_ahb_pkg::H_OKAY)
            report_problem("seed read after reset was not OKAY");
        ahb_read(`REG_STATUS, d, r);
        if (d !== 32'h0)
            report_mismatch("status after reset", d, 32'h0);
        if (r !== crc_ahb_pkg::H_OKAY)
            report_problem("status read after reset was not OKAY");
        ahb_read(`REG_RESULT, d, r);   // ~seed_reset
        if (d !== 32'h0)
            report_mismatch("result after reset", d, 32'h0);
        if (r !== crc_ahb_pkg::H_OKAY)
            report_problem("result read after reset was not OKAY");
        finish_test("reset_values");
    endtask

    task automatic test_seed_lanes();
        logic [31:0]         d;
        crc_ahb_pkg::hresp_e r;
        ahb_write(`REG_SEED, 3'b010, 32'h1357_9bdf, r);
        ahb_read(`REG_SEED, d, r);
        if (last_hrdata[63:32] !== 32'h1357_9bdf)
            report_mismatch("seed on upper lane", last_hrdata[63:32], 32'h1357_9bdf);
        if (last_hrdata[31:0] !== 32'h0)
            report_mismatch("lower lane on seed read", last_hrdata[31:0], 32'h0);
        ahb_write(`REG_SEED, 3'b000, 32'hcafe_f0a5, r);    // byte write
        ahb_read(`REG_SEED, d, r);
        if (d !== 32'h0000_00a5)
            report_mismatch("seed after byte write", d, 32'h0000_00a5);
        finish_test("seed_lanes");
    endtask

    task automatic test_single_word();
        logic [31:0]         d;
        logic [31:0]         w;
        crc_ahb_pkg::hresp_e r;
        ahb_write(`REG_SEED, 3'b010, `SEED_RESET, r);
        ahb_write(`REG_CTRL, 3'b010, 32'h1, r);            // init
        w = $random(seed);
        ahb_write(`REG_DATA, 3'b010, w, r);
        if (xfer_cycles != 1)
            report_problem("data write to an idle engine had wait states");
        ahb_read(`REG_RESULT, d, r);
        if (d !== ~crc_model(`SEED_RESET, w))
            report_mismatch("single word result", d, ~crc_model(`SEED_RESET, w));
        ahb_read(`REG_STATUS, d, r);
        if (d !== 32'h0004_0000)
            report_mismatch("status after one word", d, 32'h0004_0000);
        finish_test("single_word");
    endtask

    task automatic test_streaming();
        logic [31:0]         d;
        logic [31:0]         w;
        logic [31:0]         crc;
        logic [31:0]         s;
        int                  stalls;
        crc_ahb_pkg::hresp_e r;
        stalls = 0;
        crc    = `SEED_RESET;                              // seed left by single_word
        ahb_write(`REG_CTRL, 3'b010, 32'h1, r);
        for (int i = 0; i < 16; i++) begin
            w   = $random(seed);
            crc = crc_model(crc, w);
            ahb_write(`REG_DATA, 3'b010, w, r);
            if (xfer_cycles > 1)
                stalls++;
            if (r !== crc_ahb_pkg::H_OKAY)
                report_problem($sformatf("stream write %0d was not OKAY", i));
        end
        if (stalls != 15)                                  // all but the first wait
            report_problem($sformatf("%0d of 15 stream writes were held", stalls));
        ahb_read(`REG_RESULT, d, r);
        if (d !== ~crc)
            report_mismatch("stream result", d, ~crc);
        ahb_read(`REG_STATUS, d, r);
        if (d !== 32'h0040_0000)
            report_mismatch("status after 64 bytes", d, 32'h0040_0000);
        s   = $random(seed);                               // custom seed
        crc = s;
        ahb_write(`REG_SEED, 3'b010, s, r);
        ahb_write(`REG_CTRL, 3'b010, 32'h1, r);
        for (int i = 0; i < 4; i++) begin
            w   = $random(seed);
            crc = crc_model(crc, w);
            ahb_write(`REG_DATA, 3'b010, w, r);
        end
        ahb_read(`REG_RESULT, d, r);
        if (d !== ~crc)
            report_mismatch("result from custom seed", d, ~crc);
        finish_test("streaming");
    endtask

    task automatic test_held_read();
        logic [31:0]         d;
        logic [31:0]         w;
        logic [31:0]         crc;
        crc_ahb_pkg::hresp_e r;
        crc = 32'h0;
        ahb_write(`REG_SEED, 3'b010, crc, r);
        ahb_write(`REG_CTRL, 3'b010, 32'h1, r);
        w   = $random(seed);
        crc = crc_model(crc, w);
        ahb_write(`REG_DATA, 3'b010, w, r);
        ahb_read(`REG_RESULT, d, r);
        if (xfer_cycles != 4)                              // three busy cycles left
            report_problem($sformatf("result read took %0d data cycles, not 4", xfer_cycles));
        if (d !== ~crc)
            report_mismatch("held result read", d, ~crc);
        w = $random(seed);
        ahb_write(`REG_DATA, 3'b010, w, r);
        ahb_read(`REG_STATUS, d, r);
        if (xfer_cycles != 1)
            report_problem("status read while busy was held");
        if (d[0] !== 1'b1)
            report_mismatch("status busy bit", {31'b0, d[0]}, 32'h1);
        finish_test("held_read");
    endtask

    task automatic test_errors();
        logic [31:0]         d;
        logic [31:0]         seed_before;
        logic [31:0]         res_before;
        logic [11:0]         bad_off [4] = '{12'h020, 12'h024, `REG_RESULT, `REG_STATUS};
        crc_ahb_pkg::hresp_e r;
        ahb_read(`REG_SEED, seed_before, r);
        ahb_read(`REG_RESULT, res_before, r);              // waits out the last word
        for (int i = 0; i < 4; i++) begin
            if (i == 0)
                ahb_read(bad_off[i], d, r);
            else
                ahb_write(bad_off[i], 3'b010, 32'h0bad_0bad, r);
            if (xfer_cycles != 2 || !xfer_err_stall || r !== crc_ahb_pkg::H_ERROR)
                report_problem($sformatf("access to offset %03h gave no two-cycle ERROR",
                                         bad_off[i]));
        end
        ahb_read(`REG_SEED, d, r);
        if (d !== seed_before)
            report_mismatch("seed after errors", d, seed_before);
        ahb_read(`REG_RESULT, d, r);
        if (d !== res_before)
            report_mismatch("result after errors", d, res_before);
        finish_test("errors");
    endtask

    initial begin
        seed         = 32'h040e4b41;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        hreset_n     = 1'b0;
        haddr        = '0;
        hwdata       = '0;
        hsel         = 1'b0;
        hwrite       = 1'b0;
        htrans       = crc_ahb_pkg::IDLE;
        hsize        = 3'b010;
        repeat (10) @(posedge hclk);
        hreset_n <= 1'b1;
        test_reset_values();
        test_seed_lanes();
        test_single_word();
        test_streaming();
        test_held_read();
        test_errors();
        @(posedge hclk);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog, 20 cycles per transfer plus margin
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hdl/crc_ahb_pkg.sv
hdl/client_bus_if.sv
hdl/ahb_slv_sif.sv
hdl/crc_regs.sv
hdl/crc_engine.sv
hdl/crc_ahb_top.sv
sim/tb_crc_ahb.sv

// ==== Bender.yml ====
package:
  name: crc_ahb

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/crc_ahb_pkg.sv
      - hdl/client_bus_if.sv
      - hdl/ahb_slv_sif.sv
      - hdl/crc_regs.sv
      - hdl/crc_engine.sv
      - hdl/crc_ahb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_crc_ahb.sv
